// ==== vcache_cfg.svh ====
// --------------------
// array size and bus widths for the vcache row
// include wherever a width or count is needed
// --------------------
`ifndef VCACHE_CFG_SVH
`define VCACHE_CFG_SVH

// tiles side by side in the row
`define VC_NUM_TILES 2

// lines per tile, one word each
`define VC_SETS 8

// word address width
`define VC_ADDR_W 12

// data word width
`define VC_DATA_W 32

`endif

// ==== vcache_pkg.sv ====
// --------------------
// shared types for the vcache row: widths, bus structs, tile states
// --------------------
`default_nettype none

`include "vcache_cfg.svh"

package vcache_pkg;

  localparam int unsigned index_width_lp   = $clog2(`VC_SETS);
  localparam int unsigned tag_width_lp     = `VC_ADDR_W - index_width_lp;
  // a single tile still gets a one-bit id
  localparam int unsigned tile_id_width_lp =
    (`VC_NUM_TILES > 1) ? $clog2(`VC_NUM_TILES) : 1;

  typedef logic [`VC_ADDR_W-1:0]       addr_t;
  typedef logic [`VC_DATA_W-1:0]       data_t;
  typedef logic [index_width_lp-1:0]   index_t;
  typedef logic [tag_width_lp-1:0]     tag_t;
  typedef logic [tile_id_width_lp-1:0] tile_id_t;

  // wishbone classic, master to slave
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    data_t dat;
  } wb_req_s;

  // wishbone classic, slave to master
  typedef struct packed {
    logic  ack;
    data_t dat;
  } wb_rsp_s;

  // westward link request
  typedef struct packed {
    logic     valid;
    logic     we;
    tile_id_t tile_id;
    addr_t    addr;
    data_t    data;
  } dma_req_s;

  // eastward read response, claimed by tile_id
  typedef struct packed {
    logic     valid;
    tile_id_t tile_id;
    data_t    data;
  } dma_rsp_s;

  typedef enum logic [2:0] {
    st_idle,
    st_hit_ack,
    st_miss_send,
    st_miss_wait,
    st_write_send,
    st_done
  } tile_state_e;

endpackage

`default_nettype wire

// ==== vcache_tile.sv ====
// --------------------
// one vcache tile: direct-mapped, one-word lines, write-through, no write allocate
// core side is a wishbone classic slave, misses and writes go out on the link
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "vcache_cfg.svh"

module vcache_tile
  #(parameter vcache_pkg::tile_id_t tile_id_p = '0)
  (
    input  wire logic               clk_i
    , input  wire logic             rst_i

    , input  wire vcache_pkg::wb_req_s core_req_i
    , output vcache_pkg::wb_rsp_s      core_rsp_o

    , output vcache_pkg::dma_req_s     dma_req_o
    , input  wire logic                dma_ready_i
    , input  wire vcache_pkg::dma_rsp_s dma_rsp_i
  );

  import vcache_pkg::*;

  tile_state_e state_q;
  tile_state_e state_d;

  // line storage, only the valid bits are cleared
  logic [`VC_SETS-1:0] valid_q;
  tag_t                tag_mem  [`VC_SETS];
  data_t               data_mem [`VC_SETS];

  // request held while the FSM works on it
  addr_t  addr_q;
  data_t  data_q;

  index_t idx_i;
  tag_t   tag_i;
  index_t idx_q;
  tag_t   tag_q;
  logic   req_start;
  logic   hit_i;
  logic   hit_q;
  logic   rsp_mine;

  // lookup for the incoming core request
  assign idx_i     = core_req_i.adr[index_width_lp-1:0];
  assign tag_i     = core_req_i.adr[`VC_ADDR_W-1:index_width_lp];
  assign req_start = core_req_i.cyc && core_req_i.stb;
  assign hit_i     = valid_q[idx_i] && (tag_mem[idx_i] == tag_i);

  // lookup for the held request
  assign idx_q = addr_q[index_width_lp-1:0];
  assign tag_q = addr_q[`VC_ADDR_W-1:index_width_lp];
  assign hit_q = valid_q[idx_q] && (tag_mem[idx_q] == tag_q);

  assign rsp_mine = dma_rsp_i.valid && (dma_rsp_i.tile_id == tile_id_p);

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (req_start) begin
          if (core_req_i.we) begin
            state_d = st_write_send;
          end else if (hit_i) begin
            state_d = st_hit_ack;
          end else begin
            state_d = st_miss_send;
          end
        end
      end
      st_hit_ack: begin
        state_d = st_idle;
      end
      st_miss_send: begin
        if (dma_ready_i) begin
          state_d = st_miss_wait;
        end
      end
      st_miss_wait: begin
        if (rsp_mine) begin
          state_d = st_done;
        end
      end
      st_write_send: begin
        // ack follows acceptance by the local stage
        if (dma_ready_i) begin
          state_d = st_done;
        end
      end
      st_done: begin
        state_d = st_idle;
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else if (state_q == st_miss_wait && rsp_mine) begin
      valid_q[idx_q] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == st_idle && req_start) begin
      addr_q <= core_req_i.adr;
      // write data to send, or the hit word to return
      data_q <= core_req_i.we ? core_req_i.dat : data_mem[idx_i];
    end
    if (state_q == st_miss_wait && rsp_mine) begin
      data_q          <= dma_rsp_i.data;
      tag_mem[idx_q]  <= tag_q;
      data_mem[idx_q] <= dma_rsp_i.data;
    end
    // a write only refreshes a line it hits
    if (state_q == st_write_send && dma_ready_i && hit_q) begin
      data_mem[idx_q] <= data_q;
    end
  end

  assign core_rsp_o.ack = (state_q == st_hit_ack) || (state_q == st_done);
  assign core_rsp_o.dat = data_q;

  assign dma_req_o.valid   = (state_q == st_miss_send) || (state_q == st_write_send);
  assign dma_req_o.we      = (state_q == st_write_send);
  assign dma_req_o.tile_id = tile_id_p;
  assign dma_req_o.addr    = addr_q;
  assign dma_req_o.data    = data_q;

endmodule

`default_nettype wire

// ==== dma_link_stage.sv ====
// --------------------
// one hop of the link: requests move west, responses move east
// upstream traffic wins over the local tile
// --------------------
`timescale 1ns/1ps
`default_nettype none

module dma_link_stage
  (
    input  wire logic clk_i
    , input  wire logic rst_i

    , input  wire vcache_pkg::dma_req_s up_req_i
    , output logic                      up_ready_o

    , input  wire vcache_pkg::dma_req_s loc_req_i
    , output logic                      loc_ready_o

    , output vcache_pkg::dma_req_s      dn_req_o
    , input  wire logic                 dn_ready_i

    , input  wire vcache_pkg::dma_rsp_s rsp_i
    , output vcache_pkg::dma_rsp_s      rsp_o
  );

  import vcache_pkg::*;

  dma_req_s req_q;
  dma_rsp_s rsp_q;

  logic drain;
  logic space;
  logic take_up;
  logic take_loc;

  // register frees up when it is empty or leaving this cycle
  assign drain = req_q.valid && dn_ready_i;
  assign space = !req_q.valid || dn_ready_i;

  assign up_ready_o  = space;
  assign loc_ready_o = space && !up_req_i.valid;

  assign take_up  = up_req_i.valid && up_ready_o;
  assign take_loc = loc_req_i.valid && loc_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q.valid <= 1'b0;
    end else if (take_up) begin
      req_q <= up_req_i;
    end else if (take_loc) begin
      req_q <= loc_req_i;
    end else if (drain) begin
      req_q.valid <= 1'b0;
    end
  end

  assign dn_req_o = req_q;

  // responses are never stalled
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_q.valid <= 1'b0;
    end else begin
      rsp_q <= rsp_i;
    end
  end

  assign rsp_o = rsp_q;

endmodule

`default_nettype wire

// ==== dma_mem_bridge.sv ====
// --------------------
// west edge of the link, turns each request into one wishbone memory cycle
// read data goes back east tagged with the requesting tile
// --------------------
`timescale 1ns/1ps
`default_nettype none

module dma_mem_bridge
  (
    input  wire logic clk_i
    , input  wire logic rst_i

    , input  wire vcache_pkg::dma_req_s req_i
    , output logic                      ready_o
    , output vcache_pkg::dma_rsp_s      rsp_o

    , output vcache_pkg::wb_req_s       mem_req_o
    , input  wire vcache_pkg::wb_rsp_s  mem_rsp_i
  );

  import vcache_pkg::*;

  typedef enum logic {
    br_idle,
    br_busy
  } br_state_e;

  br_state_e state_q;
  dma_req_s  req_q;
  dma_rsp_s  rsp_q;

  assign ready_o = (state_q == br_idle);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= br_idle;
    end else if (state_q == br_idle && req_i.valid) begin
      state_q <= br_busy;
    end else if (state_q == br_busy && mem_rsp_i.ack) begin
      state_q <= br_idle;
    end
  end

  // held for the whole memory cycle
  always_ff @(posedge clk_i) begin
    if (state_q == br_idle && req_i.valid) begin
      req_q <= req_i;
    end
  end

  // writes end silently, reads answer one cycle after ack
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_q.valid <= 1'b0;
    end else if (state_q == br_busy && mem_rsp_i.ack && !req_q.we) begin
      rsp_q <= '{valid: 1'b1, tile_id: req_q.tile_id, data: mem_rsp_i.dat};
    end else begin
      rsp_q.valid <= 1'b0;
    end
  end

  assign rsp_o = rsp_q;

  always_comb begin
    mem_req_o.cyc = (state_q == br_busy);
    mem_req_o.stb = (state_q == br_busy);
    mem_req_o.we  = req_q.we;
    mem_req_o.adr = req_q.addr;
    mem_req_o.dat = req_q.data;
  end

endmodule

`default_nettype wire

// ==== vcache_array_top.sv ====
// --------------------
// row of vcache tiles sharing one memory port through a chain of link stages
// stage c sits west of tile c, the bridge sits west of stage 0
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "vcache_cfg.svh"

module vcache_array_top
  (
    input  wire logic clk_i
    , input  wire logic rst_i

    , input  wire vcache_pkg::wb_req_s [`VC_NUM_TILES-1:0] core_req_i
    , output vcache_pkg::wb_rsp_s      [`VC_NUM_TILES-1:0] core_rsp_o

    , output vcache_pkg::wb_req_s      mem_req_o
    , input  wire vcache_pkg::wb_rsp_s mem_rsp_i
  );

  import vcache_pkg::*;

  localparam int num_tiles_lp = `VC_NUM_TILES;

  // chain_req[c] enters stage c from the east, chain_req[0] feeds the bridge
  dma_req_s [num_tiles_lp:0]   chain_req;
  logic     [num_tiles_lp:0]   chain_ready;
  // chain_rsp[c+1] is what stage c shows its tile
  dma_rsp_s [num_tiles_lp:0]   chain_rsp;

  dma_req_s [num_tiles_lp-1:0] loc_req;
  logic     [num_tiles_lp-1:0] loc_ready;

  // nothing arrives from east of the last tile
  assign chain_req[num_tiles_lp] = '0;

  for (genvar c = 0; c < num_tiles_lp; c++) begin : g_col
    vcache_tile #(
      .tile_id_p(tile_id_t'(c))
    ) vcache_tile_i (
      .clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.core_req_i(core_req_i[c])
      ,.core_rsp_o(core_rsp_o[c])
      ,.dma_req_o(loc_req[c])
      ,.dma_ready_i(loc_ready[c])
      ,.dma_rsp_i(chain_rsp[c+1])
    );

    dma_link_stage dma_link_stage_i (
      .clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.up_req_i(chain_req[c+1])
      ,.up_ready_o(chain_ready[c+1])
      ,.loc_req_i(loc_req[c])
      ,.loc_ready_o(loc_ready[c])
      ,.dn_req_o(chain_req[c])
      ,.dn_ready_i(chain_ready[c])
      ,.rsp_i(chain_rsp[c])
      ,.rsp_o(chain_rsp[c+1])
    );
  end

  dma_mem_bridge dma_mem_bridge_i (
    .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.req_i(chain_req[0])
    ,.ready_o(chain_ready[0])
    ,.rsp_o(chain_rsp[0])
    ,.mem_req_o(mem_req_o)
    ,.mem_rsp_i(mem_rsp_i)
  );

endmodule

`default_nettype wire

// ==== vcache_array_properties.sv ====
// --------------------
// wishbone protocol assertions, bound to the vcache row top level
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "vcache_cfg.svh"

module vcache_array_properties
  (
    input  wire logic clk_i
    , input  wire logic rst_i
    , input  wire vcache_pkg::wb_req_s [`VC_NUM_TILES-1:0] core_req_i
    , input  wire vcache_pkg::wb_rsp_s [`VC_NUM_TILES-1:0] core_rsp_o
    , input  wire vcache_pkg::wb_req_s mem_req_o
    , input  wire vcache_pkg::wb_rsp_s mem_rsp_i
  );

  import vcache_pkg::*;

  mem_stb_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_req_o.stb |-> mem_req_o.cyc)
    else $error("memory stb high without cyc");

  // bridge holds the cycle until ack
  mem_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (mem_req_o.stb && !mem_rsp_i.ack) |=> $stable(mem_req_o))
    else $error("memory request changed before ack");

  for (genvar c = 0; c < `VC_NUM_TILES; c++) begin : g_core
    ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
      core_rsp_o[c].ack |=> !core_rsp_o[c].ack)
      else $error("core ack high for two cycles");

    ack_with_stb: assert property (@(posedge clk_i) disable iff (rst_i)
      core_rsp_o[c].ack |-> core_req_i[c].stb)
      else $error("core ack while stb low");
  end

endmodule

bind vcache_array_top vcache_array_properties vcache_array_properties_i (.*);

`default_nettype wire

// ==== tb_vcache_array.sv ====
// --------------------
// testbench for the vcache row: memory model, stimulus table and checks
// run through run_sim.sh
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "vcache_cfg.svh"

module tb_vcache_array;

  import vcache_pkg::*;

  localparam int num_tiles_lp = `VC_NUM_TILES;
  localparam int mem_words_lp = 1 << `VC_ADDR_W;
  localparam int num_tests_lp = 22;
  localparam int timeout_lp   = num_tests_lp * 40;
  localparam int ack_limit_lp = 30;
  localparam int settle_lp    = 8;

  typedef struct packed {
    tile_id_t tile;
    logic     we;
    addr_t    addr;
    data_t    wdata;
    logic     exp_mem;
    // issued together with the next entry
    logic     conc;
  } test_s;

  // tile, we, address, write data, memory access expected, concurrent
  test_s tests [num_tests_lp] = '{
    '{1'b0, 1'b0, 12'h010, 32'h0000_0000, 1'b1, 1'b0},
    '{1'b1, 1'b0, 12'h123, 32'h0000_0000, 1'b1, 1'b0},
    '{1'b0, 1'b0, 12'h010, 32'h0000_0000, 1'b0, 1'b0},
    '{1'b1, 1'b0, 12'h123, 32'h0000_0000, 1'b0, 1'b0},
    '{1'b0, 1'b1, 12'h010, 32'hcafe_0001, 1'b1, 1'b0},
    '{1'b0, 1'b0, 12'h010, 32'h0000_0000, 1'b0, 1'b0},
    '{1'b1, 1'b0, 12'h010, 32'h0000_0000, 1'b1, 1'b0},
    '{1'b1, 1'b1, 12'h234, 32'h5a5a_1234, 1'b1, 1'b0},
    '{1'b1, 1'b0, 12'h234, 32'h0000_0000, 1'b1, 1'b0},
    '{1'b0, 1'b0, 12'h045, 32'h0000_0000, 1'b1, 1'b0},
    '{1'b0, 1'b0, 12'h145, 32'h0000_0000, 1'b1, 1'b0},
    '{1'b0, 1'b0, 12'h045, 32'h0000_0000, 1'b1, 1'b0},
    '{1'b0, 1'b0, 12'h145, 32'h0000_0000, 1'b1, 1'b0},
    '{1'b0, 1'b0, 12'h300, 32'h0000_0000, 1'b1, 1'b1},
    '{1'b1, 1'b0, 12'h301, 32'h0000_0000, 1'b1, 1'b0},
    '{1'b0, 1'b1, 12'h302, 32'h0bad_0302, 1'b1, 1'b1},
    '{1'b1, 1'b1, 12'h303, 32'h0bad_0303, 1'b1, 1'b0},
    '{1'b0, 1'b0, 12'h303, 32'h0000_0000, 1'b1, 1'b1},
    '{1'b1, 1'b1, 12'h010, 32'hd00d_0010, 1'b1, 1'b0},
    '{1'b1, 1'b0, 12'h302, 32'h0000_0000, 1'b1, 1'b1},
    '{1'b0, 1'b1, 12'h145, 32'h77aa_0145, 1'b1, 1'b0},
    '{1'b0, 1'b0, 12'h145, 32'h0000_0000, 1'b0, 1'b0}
  };

  logic                       clk = 1'b0;
  logic                       rst;
  wb_req_s [num_tiles_lp-1:0] core_req;
  wb_rsp_s [num_tiles_lp-1:0] core_rsp;
  wb_req_s                    mem_req;
  wb_rsp_s                    mem_rsp = '0;

  // memory model state
  data_t       mem [mem_words_lp];
  data_t       ref_mem [mem_words_lp];
  logic [31:0] lfsr_q = 32'hda91;
  logic        filled = 1'b0;
  int          wait_left = -1;
  int          mem_cycles = 0;
  addr_t       wr_adr;
  data_t       wr_dat;

  // results of the group in flight
  data_t got_dat [2];
  data_t exp_dat [2];
  int    got_cyc [2];
  logic  got_ack [2];
  int    err_cnt = 0;
  int    pass_cnt = 0;
  int    fail_cnt = 0;
  int    cycle_cnt = 0;

  vcache_array_top vcache_array_top_i (
    .clk_i(clk)
    ,.rst_i(rst)
    ,.core_req_i(core_req)
    ,.core_rsp_o(core_rsp)
    ,.mem_req_o(mem_req)
    ,.mem_rsp_i(mem_rsp)
  );

  always #20 clk = ~clk;

  function automatic logic lfsr_bit();
    logic lsb;
    lsb    = lfsr_q[0];
    lfsr_q = {1'b0, lfsr_q[31:1]};
    if (lsb) begin
      lfsr_q = lfsr_q ^ 32'ha300_0000;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // wishbone classic memory, 0 to 3 wait cycles per access
  always @(posedge clk) begin
    #2;
    if (!filled) begin
      for (int a = 0; a < mem_words_lp; a++) begin
        mem[a] = rand_bits(32);
      end
      filled = 1'b1;
    end
    if (mem_rsp.ack) begin
      mem_rsp.ack = 1'b0;
      wait_left   = -1;
    end else if (mem_req.cyc && mem_req.stb) begin
      if (wait_left < 0) begin
        wait_left = int'(rand_bits(2));
      end
      if (wait_left == 0) begin
        mem_rsp.ack = 1'b1;
        mem_cycles++;
        if (mem_req.we) begin
          mem[mem_req.adr] = mem_req.dat;
          wr_adr           = mem_req.adr;
          wr_dat           = mem_req.dat;
        end else begin
          mem_rsp.dat = mem[mem_req.adr];
        end
      end else begin
        wait_left--;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_lp) begin
      $display("timeout after %0d cycles, the table did not finish", cycle_cnt);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic check_quiet();
    for (int t = 0; t < num_tiles_lp; t++) begin
      assert (core_rsp[t].ack === 1'b0) else begin
        $display("MISMATCH t=%0t core_rsp_o[%0d].ack got %b exp 0", $time, t, core_rsp[t].ack);
        err_cnt++;
      end
    end
    assert (mem_req.cyc === 1'b0) else begin
      $display("MISMATCH t=%0t mem_req_o.cyc got %b exp 0", $time, mem_req.cyc);
      err_cnt++;
    end
  endtask

  // one classic cycle on a core port, stb dropped after the acked edge
  task automatic run_access(input test_s t, output data_t rdata, output int cycles,
                            output logic acked);
    core_req[t.tile] = '{cyc: 1'b1, stb: 1'b1, we: t.we, adr: t.addr, dat: t.wdata};
    cycles = 0;
    acked  = 1'b0;
    while (!acked && cycles < ack_limit_lp) begin
      @(posedge clk);
      #2;
      cycles++;
      acked = core_rsp[t.tile].ack;
    end
    rdata = core_rsp[t.tile].dat;
    @(posedge clk);
    #2;
    core_req[t.tile] = '0;
  endtask

  task automatic wait_mem_cycles(input int target);
    int waited;
    waited = 0;
    while (mem_cycles < target && waited < ack_limit_lp) begin
      @(posedge clk);
      #2;
      waited++;
    end
    // room for any extra cycle to show up
    repeat (settle_lp) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic check_entry(input int idx, input int k, input logic solo);
    test_s t;
    t = tests[idx];
    if (!got_ack[k]) begin
      $display("test %0d: tile %0d gave no ack within %0d cycles", idx, t.tile, ack_limit_lp);
      err_cnt++;
    end else if (!t.we) begin
      assert (got_dat[k] == exp_dat[k]) else begin
        $display("MISMATCH t=%0t core_rsp_o[%0d].dat got %h exp %h",
                 $time, t.tile, got_dat[k], exp_dat[k]);
        err_cnt++;
      end
      // hit latency is fixed
      if (solo && !t.exp_mem) begin
        assert (got_cyc[k] == 1) else begin
          $display("MISMATCH t=%0t core_rsp_o[%0d].ack cycles got %0d exp 1",
                   $time, t.tile, got_cyc[k]);
          err_cnt++;
        end
      end
    end else if (solo) begin
      assert (wr_adr == t.addr) else begin
        $display("MISMATCH t=%0t mem_req_o.adr got %h exp %h", $time, wr_adr, t.addr);
        err_cnt++;
      end
      assert (wr_dat == t.wdata) else begin
        $display("MISMATCH t=%0t mem_req_o.dat got %h exp %h", $time, wr_dat, t.wdata);
        err_cnt++;
      end
    end
  endtask

  initial begin
    int i;
    int n;
    int exp_mem;
    int start_cycles;
    int grp_err;
    i        = 0;
    rst      = 1'b1;
    core_req = '0;
    repeat (5) begin
      @(posedge clk);
      #2;
      check_quiet();
    end
    rst = 1'b0;
    @(posedge clk);
    #2;
    check_quiet();
    $display("test reset: %s", (err_cnt == 0) ? "ok" : "failed");
    if (err_cnt == 0) pass_cnt++;
    else fail_cnt++;
    for (int a = 0; a < mem_words_lp; a++) begin
      ref_mem[a] = mem[a];
    end

    while (i < num_tests_lp) begin
      n       = (tests[i].conc && i + 1 < num_tests_lp) ? 2 : 1;
      exp_mem = 0;
      grp_err = err_cnt;
      for (int k = 0; k < n; k++) begin
        exp_dat[k] = ref_mem[tests[i+k].addr];
        if (tests[i+k].we) begin
          ref_mem[tests[i+k].addr] = tests[i+k].wdata;
        end
        exp_mem += int'(tests[i+k].exp_mem);
      end
      start_cycles = mem_cycles;
      if (n == 2) begin
        fork
          run_access(tests[i], got_dat[0], got_cyc[0], got_ack[0]);
          run_access(tests[i+1], got_dat[1], got_cyc[1], got_ack[1]);
        join
      end else begin
        run_access(tests[i], got_dat[0], got_cyc[0], got_ack[0]);
      end
      wait_mem_cycles(start_cycles + exp_mem);
      for (int k = 0; k < n; k++) begin
        check_entry(i + k, k, n == 1);
      end
      assert (mem_cycles - start_cycles == exp_mem) else begin
        $display("MISMATCH t=%0t mem_req_o cycles got %0d exp %0d",
                 $time, mem_cycles - start_cycles, exp_mem);
        err_cnt++;
      end
      for (int k = 0; k < n; k++) begin
        $display("test %0d: tile %0d %s %h: %s", i + k, tests[i+k].tile,
                 tests[i+k].we ? "write" : "read", tests[i+k].addr,
                 (err_cnt == grp_err) ? "ok" : "failed");
        if (err_cnt == grp_err) pass_cnt++;
        else fail_cnt++;
      end
      i += n;
    end

    // write-through leaves memory equal to the reference
    for (int a = 0; a < mem_words_lp; a++) begin
      assert (mem[a] == ref_mem[a]) else begin
        $display("MISMATCH t=%0t mem[%h] got %h exp %h", $time, a, mem[a], ref_mem[a]);
        err_cnt++;
      end
    end

    $display("%0d tests passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
vcache_pkg.sv
vcache_tile.sv
dma_link_stage.sv
dma_mem_bridge.sv
vcache_array_top.sv
vcache_array_properties.sv
tb_vcache_array.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator and run; the log decides pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module tb_vcache_array -o sim_vcache

status=0
./obj_dir/sim_vcache > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log || [ "$status" -ne 0 ]; then
  echo "run_sim: failure"
  exit 1
fi
echo "run_sim: success"
